// File: rtl/qmem_arbiter.sv
// Round-robin arbiter for two qmem masters sharing one bus
// Steers the granted request onto the bus and returns ack and read data

module qmem_arbiter
  import qmem_bus_pkg::*;
(
  input  logic           s_clk,
  input  logic           rst_n,
  input  logic           m0_cs,
  input  logic           m0_we,
  input  logic [MSW-1:0] m0_sel,
  input  logic [MAW-1:0] m0_adr,
  input  logic [MDW-1:0] m0_dat_w,
  output logic [MDW-1:0] m0_dat_r,
  output logic           m0_ack,
  input  logic           m1_cs,
  input  logic           m1_we,
  input  logic [MSW-1:0] m1_sel,
  input  logic [MAW-1:0] m1_adr,
  input  logic [MDW-1:0] m1_dat_w,
  output logic [MDW-1:0] m1_dat_r,
  output logic           m1_ack,
  output logic           bus_cs,
  output logic           bus_we,
  output logic [MSW-1:0] bus_sel,
  output logic [MAW-1:0] bus_adr,
  output logic [MDW-1:0] bus_dat_w,
  input  logic [MDW-1:0] bus_dat_r,
  input  logic           bus_ack
);

  logic        busy;
  master_idx_t grant;
  master_idx_t last;
  master_idx_t pick;

  // On contention the master not served last wins
  always_comb begin
    if (m0_cs && m1_cs) begin
      pick = ~last;
    end else if (m1_cs) begin
      pick = IDX_DATA;
    end else begin
      pick = IDX_FETCH;
    end
  end

  always_ff @(posedge s_clk) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      grant <= IDX_FETCH;
      last  <= IDX_DATA;
    end else if (!busy) begin
      if (m0_cs || m1_cs) begin
        busy  <= 1'b1;
        grant <= pick;
        last  <= pick;
      end
    end else if (bus_ack) begin
      // Idle for one cycle so the next request is sampled cleanly
      busy <= 1'b0;
    end
  end

  // Granted request onto the shared bus
  assign bus_cs    = busy && ((grant == IDX_DATA) ? m1_cs : m0_cs);
  assign bus_we    = (grant == IDX_DATA) ? m1_we    : m0_we;
  assign bus_sel   = (grant == IDX_DATA) ? m1_sel   : m0_sel;
  assign bus_adr   = (grant == IDX_DATA) ? m1_adr   : m0_adr;
  assign bus_dat_w = (grant == IDX_DATA) ? m1_dat_w : m0_dat_w;

  // Response goes back to the granted master only
  assign m0_ack   = busy && (grant == IDX_FETCH) && bus_ack;
  assign m1_ack   = busy && (grant == IDX_DATA) && bus_ack;
  assign m0_dat_r = (grant == IDX_FETCH) ? bus_dat_r : '0;
  assign m1_dat_r = (grant == IDX_DATA) ? bus_dat_r : '0;

endmodule

// File: rtl/qmem_bridge.sv
// Bridge from the 32-bit qmem bus to a 16-bit slave
// Each access becomes an upper-half then a lower-half slave access

module qmem_bridge
  import qmem_bus_pkg::*;
  import qmem_slave_pkg::*;
(
  input  logic           s_clk,
  input  logic           rst_n,
  input  logic           bus_cs,
  input  logic           bus_we,
  input  logic [MSW-1:0] bus_sel,
  input  logic [MAW-1:0] bus_adr,
  input  logic [MDW-1:0] bus_dat_w,
  output logic [MDW-1:0] bus_dat_r,
  output logic           bus_ack,
  output logic           s_cs,
  output logic           s_we,
  output logic [SSW-1:0] s_sel,
  output logic [SAW-1:0] s_adr,
  output logic [SDW-1:0] s_dat_w,
  input  logic [SDW-1:0] s_dat_r,
  input  logic           s_ack
);

  bridge_state_t  state;
  bridge_state_t  state_nxt;

  // Captured request
  logic           we_q;
  logic [MSW-1:0] sel_q;
  logic [MAW-1:0] adr_q;
  logic [MDW-1:0] dat_q;

  logic           active;
  logic           lower;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (bus_cs) state_nxt = U_SETUP;
      U_SETUP: state_nxt = U_WAIT;
      U_WAIT:  if (s_ack) state_nxt = L_SETUP;
      L_SETUP: state_nxt = L_WAIT;
      L_WAIT:  if (s_ack) state_nxt = ACK;
      ACK:     state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge s_clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge s_clk) begin
    if (state == IDLE && bus_cs) begin
      we_q  <= bus_we;
      sel_q <= bus_sel;
      adr_q <= bus_adr;
      dat_q <= bus_dat_w;
    end
  end

  // Read halves land as each slave access completes
  always_ff @(posedge s_clk) begin
    if (state == U_WAIT && s_ack) begin
      bus_dat_r[MDW-1 -: SDW] <= s_dat_r;
    end
    if (state == L_WAIT && s_ack) begin
      bus_dat_r[SDW-1:0] <= s_dat_r;
    end
  end

  assign bus_ack = (state == ACK);

  assign active = (state == U_SETUP) || (state == U_WAIT) ||
                  (state == L_SETUP) || (state == L_WAIT);
  assign lower  = (state == L_SETUP) || (state == L_WAIT);

  // Slave cs drops in the ack cycle
  assign s_cs    = active && !s_ack;
  assign s_we    = we_q;
  assign s_adr   = {adr_q[SAW-1:2], lower, 1'b0};
  assign s_sel   = lower ? sel_q[SSW-1:0] : sel_q[MSW-1 -: SSW];
  assign s_dat_w = lower ? dat_q[SDW-1:0] : dat_q[MDW-1 -: SDW];

endmodule

// File: rtl/qmem_bus_pkg.sv
// Master-side qmem bus definitions
// Widths of the 32-bit bus and the index of the granted master

package qmem_bus_pkg;

  // Byte address width
  localparam int MAW = 22;

  // Byte selects, one per data byte
  localparam int MSW = 4;

  // Data width
  localparam int MDW = 32;

  // Granted master, 0 is fetch and 1 is data
  typedef logic master_idx_t;

  localparam master_idx_t IDX_FETCH = 1'b0;
  localparam master_idx_t IDX_DATA  = 1'b1;

endpackage

// File: rtl/qmem_slave_pkg.sv
// Slave-side qmem definitions
// Widths of the 16-bit SRAM port and the bridge state encoding

package qmem_slave_pkg;

  localparam int SAW = 22;
  localparam int SSW = 2;
  localparam int SDW = 16;

  typedef enum logic [2:0] {
    IDLE    = 3'b000,
    U_SETUP = 3'b010,
    U_WAIT  = 3'b011,
    L_SETUP = 3'b100,
    L_WAIT  = 3'b101,
    ACK     = 3'b111
  } bridge_state_t;

endpackage

// File: rtl/qmem_sram16.sv
// 16-bit synchronous SRAM slave with byte selects
// Acknowledges each access after a configurable number of wait states

module qmem_sram16
  import qmem_slave_pkg::*;
#(
  parameter int MEM_WORDS   = 1024,
  parameter int WAIT_STATES = 1
) (
  input  logic           s_clk,
  input  logic           rst_n,
  input  logic           s_cs,
  input  logic           s_we,
  input  logic [SSW-1:0] s_sel,
  input  logic [SAW-1:0] s_adr,
  input  logic [SDW-1:0] s_dat_w,
  output logic [SDW-1:0] s_dat_r,
  output logic           s_ack
);

  localparam int IW = $clog2(MEM_WORDS);
  localparam int CW = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [SDW-1:0] mem [MEM_WORDS];
  logic [CW-1:0]  wait_cnt;
  logic           done;
  logic [IW-1:0]  idx;

  // Halfword index from the byte address
  assign idx  = s_adr[IW:1];
  assign done = s_cs && !s_ack && (wait_cnt == CW'(WAIT_STATES));

  always_ff @(posedge s_clk) begin
    if (!rst_n) begin
      wait_cnt <= '0;
      s_ack    <= 1'b0;
    end else begin
      s_ack <= done;
      if (done) begin
        wait_cnt <= '0;
      end else if (s_cs && !s_ack) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  // Access happens on the edge that raises s_ack
  always_ff @(posedge s_clk) begin
    if (done) begin
      s_dat_r <= mem[idx];
      if (s_we && s_sel[1]) mem[idx][15:8] <= s_dat_w[15:8];
      if (s_we && s_sel[0]) mem[idx][7:0]  <= s_dat_w[7:0];
    end
  end

endmodule

// File: rtl/qmem_top.sv
// Memory subsystem top level
// Two qmem masters through the arbiter and bridge into a 16-bit SRAM

module qmem_top
  import qmem_bus_pkg::*;
  import qmem_slave_pkg::*;
#(
  parameter int MEM_WORDS   = 1024,
  parameter int WAIT_STATES = 1
) (
  input  logic           s_clk,
  input  logic           rst_n,
  input  logic           m0_cs,
  input  logic           m0_we,
  input  logic [MSW-1:0] m0_sel,
  input  logic [MAW-1:0] m0_adr,
  input  logic [MDW-1:0] m0_dat_w,
  output logic [MDW-1:0] m0_dat_r,
  output logic           m0_ack,
  input  logic           m1_cs,
  input  logic           m1_we,
  input  logic [MSW-1:0] m1_sel,
  input  logic [MAW-1:0] m1_adr,
  input  logic [MDW-1:0] m1_dat_w,
  output logic [MDW-1:0] m1_dat_r,
  output logic           m1_ack
);

  // Shared 32-bit bus
  logic           bus_cs;
  logic           bus_we;
  logic [MSW-1:0] bus_sel;
  logic [MAW-1:0] bus_adr;
  logic [MDW-1:0] bus_dat_w;
  logic [MDW-1:0] bus_dat_r;
  logic           bus_ack;

  // 16-bit slave port
  logic           s_cs;
  logic           s_we;
  logic [SSW-1:0] s_sel;
  logic [SAW-1:0] s_adr;
  logic [SDW-1:0] s_dat_w;
  logic [SDW-1:0] s_dat_r;
  logic           s_ack;

  qmem_arbiter u_arbiter (.*);

  qmem_bridge u_bridge (.*);

  qmem_sram16 #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) u_sram (.*);

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the qmem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module qmem_tb -o Vqmem_tb
if [ $? -ne 0 ]; then
  echo "Compile step failed"
  exit 1
fi

out=$(./obj_dir/Vqmem_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Testbench passed"; then
  exit 0
fi
exit 1

// File: sim.f
rtl/qmem_bus_pkg.sv
rtl/qmem_slave_pkg.sv
rtl/qmem_arbiter.sv
rtl/qmem_bridge.sv
rtl/qmem_sram16.sv
rtl/qmem_top.sv
test/qmem_bridge_assert.sv
test/qmem_tb.sv

// File: test/qmem_bridge_assert.sv
// Protocol assertions on the qmem bridge
// Bound into every qmem_bridge instance

module qmem_bridge_assert
  import qmem_slave_pkg::*;
(
  input logic           s_clk,
  input logic           rst_n,
  input bridge_state_t  state,
  input logic           s_cs,
  input logic           s_we,
  input logic [SSW-1:0] s_sel,
  input logic [SAW-1:0] s_adr,
  input logic [SDW-1:0] s_dat_w,
  input logic           s_ack,
  input logic           bus_ack
);

  a_legal_state: assert property (@(posedge s_clk) disable iff (!rst_n)
    state inside {IDLE, U_SETUP, U_WAIT, L_SETUP, L_WAIT, ACK})
    else $error("bridge entered an illegal state");

  // Fields hold until the slave acks
  a_stable_wait: assert property (@(posedge s_clk) disable iff (!rst_n)
    s_cs |=> (s_ack || (s_cs && $stable(s_we) && $stable(s_sel) &&
                        $stable(s_adr) && $stable(s_dat_w))))
    else $error("slave request changed while waiting for s_ack");

  a_lower_order: assert property (@(posedge s_clk) disable iff (!rst_n)
    (state == L_SETUP) |-> ($past(state) == U_WAIT))
    else $error("L_SETUP not entered from U_WAIT");

  a_ack_pulse: assert property (@(posedge s_clk) disable iff (!rst_n)
    bus_ack |=> !bus_ack)
    else $error("bus_ack longer than one cycle");

  a_half_align: assert property (@(posedge s_clk) disable iff (!rst_n)
    s_cs |-> (s_adr[0] == 1'b0))
    else $error("slave address not halfword aligned");

endmodule

bind qmem_bridge qmem_bridge_assert u_bridge_assert (.*);

// File: test/qmem_tb.sv
// Testbench for the qmem memory subsystem
// Two masters, a reference halfword memory and checks at every ack

module qmem_tb
  import qmem_bus_pkg::*;
;

  localparam int NUM_TRANS  = 58;
  localparam int MAX_CYCLES = 60 * 20;
  localparam int POOL       = 8;

  logic           s_clk;
  logic           rst_n;
  logic           m0_cs;
  logic           m0_we;
  logic [MSW-1:0] m0_sel;
  logic [MAW-1:0] m0_adr;
  logic [MDW-1:0] m0_dat_w;
  logic [MDW-1:0] m0_dat_r;
  logic           m0_ack;
  logic           m1_cs;
  logic           m1_we;
  logic [MSW-1:0] m1_sel;
  logic [MAW-1:0] m1_adr;
  logic [MDW-1:0] m1_dat_w;
  logic [MDW-1:0] m1_dat_r;
  logic           m1_ack;

  logic [15:0]    ref_mem [1024];
  logic [31:0]    rng;
  int             cycles;
  int             n_acks;
  master_idx_t    last_served;
  master_idx_t    exp_order [$];

  qmem_top #(
    .MEM_WORDS   (1024),
    .WAIT_STATES (1)
  ) UUT (.*);

  initial begin
    s_clk = 1'b0;
    forever #2 s_clk = ~s_clk;
  end

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [MAW-1:0] pool_adr(input int k);
    return MAW'(k) << 2;
  endfunction

  // Upper half sits at byte offset 0 and lower half at offset 2
  function automatic logic [MDW-1:0] ref_read(input logic [MAW-1:0] adr);
    return {ref_mem[{adr[10:2], 1'b0}], ref_mem[{adr[10:2], 1'b1}]};
  endfunction

  task automatic ref_write(input logic [MAW-1:0] adr, input logic [MSW-1:0] sel,
                           input logic [MDW-1:0] dat);
    logic [9:0] up;
    logic [9:0] lo;
    up = {adr[10:2], 1'b0};
    lo = {adr[10:2], 1'b1};
    if (sel[3]) ref_mem[up][15:8] = dat[31:24];
    if (sel[2]) ref_mem[up][7:0]  = dat[23:16];
    if (sel[1]) ref_mem[lo][15:8] = dat[15:8];
    if (sel[0]) ref_mem[lo][7:0]  = dat[7:0];
  endtask

  task automatic fail_plain(input string what);
    $display("%s at time %0t", what, $time);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [MDW-1:0] act,
                            input logic [MDW-1:0] exp);
    if (act !== exp) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, name, act, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic check_master(input string name, input master_idx_t act,
                              input master_idx_t exp);
    if (act !== exp) begin
      $display("Error at time %0t: %s is %0d, expected %0d", $time, name, act, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // Request fields are still held by the master in its ack cycle
  task automatic handle_ack(input master_idx_t idx);
    logic           we;
    logic [MSW-1:0] sel;
    logic [MAW-1:0] adr;
    logic [MDW-1:0] dat_w;
    logic [MDW-1:0] dat_r;
    we    = (idx == IDX_DATA) ? m1_we : m0_we;
    sel   = (idx == IDX_DATA) ? m1_sel : m0_sel;
    adr   = (idx == IDX_DATA) ? m1_adr : m0_adr;
    dat_w = (idx == IDX_DATA) ? m1_dat_w : m0_dat_w;
    dat_r = (idx == IDX_DATA) ? m1_dat_r : m0_dat_r;
    if (we) begin
      ref_write(adr, sel, dat_w);
    end else begin
      check_data((idx == IDX_DATA) ? "m1_dat_r" : "m0_dat_r", dat_r, ref_read(adr));
    end
    if (exp_order.size() > 0) begin
      check_master("granted master", idx, exp_order.pop_front());
    end
    last_served = idx;
    n_acks++;
  endtask

  always @(negedge s_clk) begin
    if (rst_n) begin
      if (m0_ack && m1_ack) begin
        fail_plain("Both masters were acknowledged in the same cycle");
      end else if (m0_ack) begin
        handle_ack(IDX_FETCH);
      end else if (m1_ack) begin
        handle_ack(IDX_DATA);
      end
    end
  end

  always @(posedge s_clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      fail_plain("Timeout, the tests did not finish in time");
    end
  end

  // One request held until its ack
  task automatic issue(input master_idx_t idx, input logic we, input logic [MSW-1:0] sel,
                       input logic [MAW-1:0] adr, input logic [MDW-1:0] dat);
    if (idx == IDX_DATA) begin
      {m1_cs, m1_we, m1_sel, m1_adr, m1_dat_w} = {1'b1, we, sel, adr, dat};
    end else begin
      {m0_cs, m0_we, m0_sel, m0_adr, m0_dat_w} = {1'b1, we, sel, adr, dat};
    end
    do @(negedge s_clk); while (!((idx == IDX_DATA) ? m1_ack : m0_ack));
    @(posedge s_clk);
    #1;
    if (idx == IDX_DATA) m1_cs = 1'b0;
    else m0_cs = 1'b0;
  endtask

  task automatic random_traffic(input master_idx_t idx, input int count);
    int gap;
    for (int i = 0; i < count; i++) begin
      gap = int'(xorshift() % 4);
      repeat (gap) begin
        @(posedge s_clk);
        #1;
      end
      issue(idx, xorshift() % 2 == 0, MSW'(xorshift()), pool_adr(int'(xorshift() % POOL)),
            xorshift());
    end
  endtask

  initial begin
    rng         = 32'hd9a7;
    cycles      = 0;
    n_acks      = 0;
    last_served = IDX_DATA;
    rst_n       = 1'b0;
    {m0_cs, m0_we, m0_sel, m0_adr, m0_dat_w} = '0;
    {m1_cs, m1_we, m1_sel, m1_adr, m1_dat_w} = '0;
    repeat (5) @(posedge s_clk);
    #1;
    rst_n = 1'b1;

    // No ack without a request
    repeat (10) begin
      @(negedge s_clk);
      if (m0_ack || m1_ack) fail_plain("An ack was seen with no request pending");
    end
    @(posedge s_clk);
    #1;

    // Simultaneous writes right after reset where fetch is preferred
    exp_order.push_back(~last_served);
    exp_order.push_back(last_served);
    fork
      issue(IDX_FETCH, 1'b1, 4'hf, pool_adr(0), xorshift());
      issue(IDX_DATA, 1'b1, 4'hf, pool_adr(1), xorshift());
    join

    // Full words through one master and read back through the other
    for (int k = 0; k < POOL; k++) begin
      issue(master_idx_t'(k % 2), 1'b1, 4'hf, pool_adr(k), xorshift());
      issue(master_idx_t'((k + 1) % 2), 1'b0, 4'h0, pool_adr(k), '0);
    end

    // Partial writes then full reads
    for (int k = 0; k < 6; k++) begin
      issue(IDX_DATA, 1'b1, MSW'(xorshift()), pool_adr(k), xorshift());
    end
    for (int k = 0; k < POOL; k++) begin
      issue(IDX_FETCH, 1'b0, 4'h0, pool_adr(k), '0);
    end

    // Contention alternates starting with the master not served last
    for (int k = 0; k < 10; k++) begin
      exp_order.push_back((k % 2 == 0) ? ~last_served : last_served);
    end
    fork
      for (int k = 0; k < 5; k++) issue(IDX_FETCH, 1'b0, 4'h0, pool_adr(k), '0);
      for (int k = 0; k < 5; k++) issue(IDX_DATA, 1'b0, 4'h0, pool_adr(k + 3), '0);
    join

    fork
      random_traffic(IDX_FETCH, 8);
      random_traffic(IDX_DATA, 8);
    join

    repeat (4) @(posedge s_clk);
    if (n_acks != NUM_TRANS) begin
      $display("Only %0d of %0d transactions were acknowledged", n_acks, NUM_TRANS);
      $display("Testbench failed");
      $fatal(1);
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule
